// File: files.f
logic/reset_chain_pkg.sv
logic/done_sync.sv
logic/step_timer.sv
logic/reset_sequencer.sv
logic/step_status.sv
logic/reset_chain.sv
dv/reset_chain_properties.sv
dv/reset_chain_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the reset_chain testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=reset_chain_sim

verilator --binary --assert --timescale 1ns/1ps \
	--top-module reset_chain_tb -f files.f -o "$BIN"
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
	echo "simulation reported a failure, see $LOG"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
	echo "simulation ended without a result line"
	exit 1
fi
echo "simulation finished cleanly"
exit 0

// File: dv/reset_chain_tb.sv
`timescale 1ns/1ps

// drives reset_chain through power-on and requested chains
module reset_chain_tb import reset_chain_pkg::*; ();

	localparam int NCHAIN = 4; // power-on chain plus three requested
	localparam int MAX_DELAY = 100; // longest done delay of a live step
	localparam int TIMEOUT_CYCLES =
		NCHAIN * NSTEP * (READY_LEN + RESET_LEN + DONE_TIMEOUT + 20) + 500;
	localparam logic [31:0] SEED = 32'h84bf_500a;

	typedef int delay_row_t [NSTEP]; // done delay per step in cycles

	logic hw;
	logic poweronreset = 1'b1;
	logic req_valid = 1'b0;
	logic req_ready;
	wire [NSTEP-1:0] done_criteria; // one model per bit
	step_vec_t reset_out;
	chain_status_t status;

	delay_row_t delay_tab [NCHAIN];
	step_vec_t dead_tab [NCHAIN]; // steps that never answer
	int cur_row; // chain the models follow
	int chain_cnt = 0; // chains seen starting by the comparator
	int checked_chains = 0;
	int chains_seen = 0; // chain starts seen by the pulse monitor
	int cycle_cnt = 0;
	int pulse_len = 0;
	int pulse_cnt = 0; // reset pulses in the running chain
	int gap_len = 0; // low cycles since the last pulse
	logic busy_seen = 1'b0;

	reset_chain dut0 (
		.hw(hw),
		.poweronreset(poweronreset),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.done_criteria(done_criteria),
		.reset_out(reset_out),
		.status(status)
	);

	initial begin
		hw = 1'b0;
		forever #20 hw = ~hw; // 40 ns period
	end

	task automatic abort_run;
		$display("Verification failed");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic compare_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("error: %s is 0x%h, expected 0x%h", name, actual, expected);
			abort_run();
		end
	endtask

	// done when the criterion reaches the sequencer before its timeout
	function automatic chain_status_t expected_status(input delay_row_t delays,
		input step_vec_t dead);
		chain_status_t exp_st;
		exp_st = '0; // busy low at chain end
		for (int i = 0; i < NSTEP; i++) begin
			if (!dead[i] && delays[i] <= DONE_TIMEOUT - SYNC_STAGES) begin
				exp_st.done[i] = 1'b1;
			end else begin
				exp_st.error[i] = 1'b1;
			end
		end
		return exp_st;
	endfunction

	// hold req_valid until the handshake and drop it after
	task automatic request_chain(input logic expect_wait);
		int waited;
		waited = 0;
		@(negedge hw);
		req_valid = 1'b1;
		while (!req_ready) begin
			compare_value("status.busy", 32'(status.busy), 1); // ready low only while busy
			waited++; // back-pressure from a running chain
			@(negedge hw);
		end
		compare_value("status.busy", 32'(status.busy), 0); // ready only when idle
		if (expect_wait && waited == 0) begin
			$display("request raised during a chain was accepted without waiting");
			abort_run();
		end
		@(negedge hw); // rising edge in between took the request
		req_valid = 1'b0;
		compare_value("status.busy", 32'(status.busy), 1);
	endtask

	assign cur_row = (chain_cnt > 0) ? chain_cnt - 1 : 0;

	// subsystem models drop the criterion with reset and raise it after the delay
	for (genvar g = 0; g < NSTEP; g++) begin : g_done_model
		logic crit_q = 1'b0;
		logic waiting_q = 1'b0; // reset seen and criterion still low
		int low_cnt = 0;

		assign done_criteria[g] = crit_q;

		always @(negedge hw) begin
			if (poweronreset) begin
				crit_q <= 1'b0;
				waiting_q <= 1'b0;
				low_cnt <= 0;
			end else if (reset_out[g]) begin
				crit_q <= 1'b0;
				waiting_q <= 1'b1;
				low_cnt <= 0;
			end else if (waiting_q && !dead_tab[cur_row][g]) begin
				if (low_cnt + 1 >= delay_tab[cur_row][g]) begin
					crit_q <= 1'b1; // subsystem up
					waiting_q <= 1'b0;
				end else begin
					low_cnt <= low_cnt + 1;
				end
			end
		end
	end

	// reset pulse order, width and spacing
	always @(negedge hw) begin
		if (!poweronreset) begin
			if (status.busy && !busy_seen) begin
				chains_seen++;
				pulse_cnt = 0;
			end
			if (!status.busy && busy_seen) begin
				compare_value("reset pulses per chain", pulse_cnt, NSTEP); // ran to the last step
			end
			busy_seen = status.busy;
			if (reset_out != '0) begin
				if (pulse_len == 0) begin
					compare_value("reset_out", 32'(reset_out), 32'(step_vec_t'(1) << pulse_cnt));
					if (pulse_cnt != 0 && gap_len < READY_LEN) begin
						$display("reset of step %0d rose %0d cycles after the previous one fell",
							pulse_cnt, gap_len);
						abort_run();
					end
				end
				pulse_len++;
			end else begin
				if (pulse_len != 0) begin
					compare_value("reset_out pulse length", pulse_len, RESET_LEN);
					pulse_cnt++;
					gap_len = 0;
				end
				pulse_len = 0;
				gap_len++;
			end
		end
	end

	// status at each chain start and end
	initial begin
		chain_status_t exp_st;
		for (int c = 0; c < NCHAIN; c++) begin
			@(posedge status.busy);
			chain_cnt = c + 1;
			@(negedge hw);
			compare_value("status.done", 32'(status.done), 0); // cleared by chain start
			compare_value("status.error", 32'(status.error), 0);
			@(negedge status.busy);
			@(negedge hw);
			exp_st = expected_status(delay_tab[c], dead_tab[c]);
			compare_value("status", 32'(status), 32'(exp_st));
			checked_chains = c + 1;
		end
	end

	always @(posedge hw) begin
		cycle_cnt++;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the chains did not finish", cycle_cnt);
			abort_run();
		end
	end

	initial begin
		void'($urandom(SEED));
		for (int c = 0; c < NCHAIN; c++) begin
			for (int i = 0; i < NSTEP; i++) begin
				delay_tab[c][i] = int'($urandom_range(MAX_DELAY, 1));
			end
		end
		dead_tab[0] = '0;
		dead_tab[1] = step_vec_t'(1) << $urandom_range(NSTEP - 1, 0); // one dead step
		dead_tab[2] = step_vec_t'(1) | (step_vec_t'(1) << (NSTEP - 1)); // first and last
		dead_tab[3] = '0;

		@(negedge hw); // one rising edge under reset
		compare_value("reset_out", 32'(reset_out), 0);
		compare_value("req_ready", 32'(req_ready), 0);
		compare_value("status", 32'(status), 0);
		@(negedge hw);
		poweronreset = 1'b0;

		// power-on chain with no request
		@(negedge hw);
		compare_value("status.busy", 32'(status.busy), 1);
		compare_value("req_ready", 32'(req_ready), 0);

		wait (checked_chains == 1);
		request_chain(1'b0); // idle so taken at once
		wait (chain_cnt == 2 && reset_out[2]);
		request_chain(1'b1); // mid-chain so held back
		wait (checked_chains == 3);
		request_chain(1'b0);
		wait (checked_chains == NCHAIN);

		repeat (50) @(negedge hw); // no extra chain afterwards
		compare_value("status.busy", 32'(status.busy), 0);
		compare_value("chains started", chains_seen, NCHAIN);
		$display("Verification passed");
		$finish;
	end

endmodule

// File: dv/reset_chain_properties.sv
`timescale 1ns/1ps

// protocol rules checked inside reset_chain
module reset_chain_properties import reset_chain_pkg::*; (
	input logic hw,
	input logic poweronreset,
	input logic req_ready,
	input step_vec_t reset_out,
	input chain_status_t status
);

	int high_len = 0; // samples the current reset pulse has been high

	always_ff @(posedge hw) begin
		if (poweronreset || reset_out == '0) begin
			high_len <= 0;
		end else begin
			high_len <= high_len + 1;
		end
	end

	one_reset_at_a_time: assert property (@(posedge hw) disable iff (poweronreset)
		$onehot0(reset_out))
		else $error("more than one reset_out bit high: %b", reset_out);

	ready_only_when_idle: assert property (@(posedge hw) disable iff (poweronreset)
		!(req_ready && status.busy))
		else $error("req_ready and busy high together");

	done_or_error: assert property (@(posedge hw) disable iff (poweronreset)
		(status.done & status.error) == '0)
		else $error("step flagged done and error: %b %b", status.done, status.error);

	// pulse just ended, its width must be exact
	pulse_width: assert property (@(posedge hw) disable iff (poweronreset)
		(reset_out == '0 && high_len != 0) |-> (high_len == RESET_LEN))
		else $error("reset_out pulse lasted %0d cycles", high_len);

endmodule

bind reset_chain reset_chain_properties props0 (
	.hw(hw),
	.poweronreset(poweronreset),
	.req_ready(req_ready),
	.reset_out(reset_out),
	.status(status)
);

// File: logic/reset_chain.sv
`timescale 1ns/1ps

// chained reset sequencer top
module reset_chain import reset_chain_pkg::*; (
	input logic hw,
	input logic poweronreset,
	input logic req_valid, // request a new chain
	output logic req_ready,
	input step_vec_t done_criteria, // from the subsystems
	output step_vec_t reset_out, // to the subsystems
	output chain_status_t status
);

	step_vec_t done_synced;
	logic timer_load;
	cycle_cnt_t timer_value;
	logic timer_expired;
	logic chain_start;
	logic busy;
	step_event_t step_evt;
	step_vec_t done_vec;
	step_vec_t error_vec;

	done_sync done_sync0 (
		.hw(hw),
		.poweronreset(poweronreset),
		.done_criteria(done_criteria),
		.done_synced(done_synced)
	);

	step_timer step_timer0 (
		.hw(hw),
		.poweronreset(poweronreset),
		.load(timer_load),
		.load_value(timer_value),
		.expired(timer_expired)
	);

	reset_sequencer reset_sequencer0 (
		.hw(hw),
		.poweronreset(poweronreset),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.done_synced(done_synced),
		.expired(timer_expired),
		.load(timer_load),
		.load_value(timer_value),
		.reset_out(reset_out),
		.chain_start(chain_start),
		.busy(busy),
		.step_evt(step_evt)
	);

	step_status step_status0 (
		.hw(hw),
		.poweronreset(poweronreset),
		.chain_start(chain_start),
		.step_evt(step_evt),
		.done(done_vec),
		.error(error_vec)
	);

	// status word
	assign status.busy = busy;
	assign status.done = done_vec;
	assign status.error = error_vec;

endmodule

// File: logic/step_status.sv
`timescale 1ns/1ps

// done and error record of the last chain
module step_status import reset_chain_pkg::*; (
	input logic hw,
	input logic poweronreset,
	input logic chain_start, // wipe both vectors
	input step_event_t step_evt,
	output step_vec_t done,
	output step_vec_t error
);

	step_vec_t done_q;
	step_vec_t error_q;
	step_vec_t evt_bit; // one-hot of the reporting step

	assign evt_bit = step_vec_t'(1) << step_evt.idx;

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			done_q <= '0;
			error_q <= '0;
		end else if (chain_start) begin
			done_q <= '0; // new chain, old result gone
			error_q <= '0;
		end else if (step_evt.valid) begin
			// exactly one of the two per step
			if (step_evt.ok) begin
				done_q <= done_q | evt_bit;
			end else begin
				error_q <= error_q | evt_bit;
			end
		end
	end

	// held until the next chain_start
	assign done = done_q;
	assign error = error_q;

endmodule

// File: logic/reset_sequencer.sv
`timescale 1ns/1ps

// walks the steps one after another
// per step: hold-off, reset pulse, wait for done or timeout
module reset_sequencer import reset_chain_pkg::*; (
	input logic hw,
	input logic poweronreset,
	input logic req_valid, // hardware reset request
	output logic req_ready, // only in idle
	input step_vec_t done_synced,
	input logic expired, // from step_timer
	output logic load,
	output cycle_cnt_t load_value,
	output step_vec_t reset_out, // one-hot or zero
	output logic chain_start, // one cycle, clears status
	output logic busy,
	output step_event_t step_evt // end of a step
);

	seq_state_t state_q;
	seq_state_t state_d;
	step_idx_t step_idx; // current step
	logic boot_pending; // power-on counts as a request
	logic done_hit; // criterion of the current step
	logic last_step;

	assign done_hit = done_synced[step_idx];
	assign last_step = (step_idx == step_idx_t'(NSTEP - 1));

	// handshake
	// boot_pending holds ready low through reset and the first chain start
	assign req_ready = (state_q == SEQ_IDLE) && !boot_pending;
	assign chain_start = (state_q == SEQ_IDLE) && (boot_pending || req_valid);
	assign busy = (state_q != SEQ_IDLE);

	// next state, timer loads and step events
	always_comb begin
		state_d = state_q;
		load = 1'b0;
		load_value = '0;
		step_evt = '0;
		case (state_q)
			SEQ_IDLE: begin
				if (chain_start) begin
					state_d = SEQ_HOLD;
					load = 1'b1;
					load_value = HOLD_LOAD;
				end
			end
			SEQ_HOLD: begin
				if (expired) begin // hold-off over
					state_d = SEQ_RESET;
					load = 1'b1;
					load_value = RESET_LOAD;
				end
			end
			SEQ_RESET: begin
				if (expired) begin // pulse done, start timeout
					state_d = SEQ_WAIT_DONE;
					load = 1'b1;
					load_value = WAIT_LOAD;
				end
			end
			SEQ_WAIT_DONE: begin
				// done wins over a timeout in the same cycle
				if (done_hit || expired) begin
					step_evt.valid = 1'b1;
					step_evt.idx = step_idx;
					step_evt.ok = done_hit;
					if (last_step) begin
						state_d = SEQ_IDLE; // chain finished
					end else begin
						state_d = SEQ_HOLD; // on to the next step
						load = 1'b1;
						load_value = HOLD_LOAD;
					end
				end
			end
			default: begin
				state_d = SEQ_IDLE;
			end
		endcase
	end

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			state_q <= SEQ_IDLE;
			step_idx <= '0;
			boot_pending <= 1'b1; // chain starts once reset is released
		end else begin
			state_q <= state_d;
			if (chain_start) begin
				step_idx <= '0;
				boot_pending <= 1'b0;
			end else if (step_evt.valid && !last_step) begin
				step_idx <= step_idx + 1'b1;
			end
		end
	end

	// reset lines straight from flops
	// step_idx does not change on the way into SEQ_RESET
	// so the registered line lines up with state_q
	always_ff @(posedge hw) begin
		if (poweronreset) begin
			reset_out <= '0;
		end else if (state_d == SEQ_RESET) begin
			reset_out <= step_vec_t'(1) << step_idx;
		end else begin
			reset_out <= '0;
		end
	end

endmodule

// File: logic/step_timer.sv
`timescale 1ns/1ps

// one shared timer for hold-off, reset pulse and done timeout
// only one phase runs at a time, so a single counter covers all three
module step_timer import reset_chain_pkg::*; (
	input logic hw,
	input logic poweronreset,
	input logic load, // phase entry
	input cycle_cnt_t load_value, // phase length minus one
	output logic expired // count at zero
);

	cycle_cnt_t count_q;

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			count_q <= '0;
		end else if (load) begin
			count_q <= load_value; // restart for the new phase
		end else if (count_q != '0) begin
			count_q <= count_q - 1'b1; // stops at zero
		end
	end

	// high in the last cycle of a phase
	// a phase loaded with n-1 therefore lasts n cycles
	assign expired = (count_q == '0);

endmodule

// File: logic/done_sync.sv
`timescale 1ns/1ps

// done criteria come from blocks outside the hw domain
module done_sync import reset_chain_pkg::*; (
	input logic hw,
	input logic poweronreset,
	input step_vec_t done_criteria, // raw, asynchronous
	output step_vec_t done_synced // SYNC_STAGES cycles later
);

	step_vec_t stage_q [SYNC_STAGES]; // stage 0 samples the pins

	always_ff @(posedge hw) begin
		if (poweronreset) begin
			for (int s = 0; s < SYNC_STAGES; s++) begin
				stage_q[s] <= '0;
			end
		end else begin
			stage_q[0] <= done_criteria; // first flop, may go metastable
			for (int s = 1; s < SYNC_STAGES; s++) begin
				stage_q[s] <= stage_q[s-1];
			end
		end
	end

	assign done_synced = stage_q[SYNC_STAGES-1]; // last stage only

endmodule

// File: logic/reset_chain_pkg.sv
package reset_chain_pkg;

	// chain geometry
	localparam int NSTEP = 6; // subsystems brought up in order
	localparam int READY_LEN = 20; // hold-off before each reset
	localparam int RESET_LEN = 20; // reset pulse width
	localparam int DONE_TIMEOUT = 200; // max wait for a done criterion
	localparam int SYNC_STAGES = 2; // flops on the done inputs

	// widths with a meaning
	typedef logic [NSTEP-1:0] step_vec_t; // one bit per step
	typedef logic [2:0] step_idx_t; // step number
	typedef logic [15:0] cycle_cnt_t; // timer count

	// timer reload values
	// the timer flags at zero, so a phase of n cycles loads n-1
	localparam cycle_cnt_t HOLD_LOAD = cycle_cnt_t'(READY_LEN - 1);
	localparam cycle_cnt_t RESET_LOAD = cycle_cnt_t'(RESET_LEN - 1);
	localparam cycle_cnt_t WAIT_LOAD = cycle_cnt_t'(DONE_TIMEOUT - 1);

	// sequencer states
	typedef enum logic [1:0] {
		SEQ_IDLE, // waiting for a request or power-on
		SEQ_HOLD, // hold-off before the step reset
		SEQ_RESET, // step reset high
		SEQ_WAIT_DONE // waiting on the done criterion
	} seq_state_t;

	// end of one step
	typedef struct packed {
		logic valid; // one cycle per step
		step_idx_t idx; // which step finished
		logic ok; // done seen, clear on timeout
	} step_event_t;

	// what the top reports
	typedef struct packed {
		logic busy; // chain running
		step_vec_t done; // steps that answered
		step_vec_t error; // steps that timed out
	} chain_status_t;

endpackage
